// ==== console_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module console_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  wire        CLK,
    input  wire        reset,
    input  wire        rx_valid,
    input  wire [7:0]  rx_data,
    input  wire        pop,
    output logic [7:0] head_data
);
    localparam int PTR_W = $clog2(FIFO_DEPTH);

    logic [7:0]       store [FIFO_DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W:0]   count;
    logic             full;
    logic             empty;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == (PTR_W + 1)'(FIFO_DEPTH));
    assign empty   = (count == '0);
    assign do_push = rx_valid && !full;
    assign do_pop  = pop && !empty;

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge CLK) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                tail <= tail + 1'b1;
            end
            if (do_pop) begin
                head <= head + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (do_push) begin
            store[tail] <= rx_data;
        end
    end

    // Byte for the response cycle, zero when read empty
    always_ff @(posedge CLK) begin
        if (pop) begin
            head_data <= do_pop ? store[head] : 8'h00;
        end
    end

    assert property (@(posedge CLK) disable iff (reset)
        count <= FIFO_DEPTH);

endmodule

`default_nettype wire

// ==== host_cmd.sv ====
`timescale 1ns/1ps
`default_nettype none

module host_cmd #(
    parameter logic [31:0] TOHOST_ADDR = 32'h4000_8000
) (
    input  wire        CLK,
    input  wire        reset,
    input  wire [31:0] wr_addr,
    input  wire [31:0] wr_data,
    input  wire        wr_en,
    output logic       char_we,
    output logic [7:0] char_data,
    output logic       finish
);
    import mem_pkg::*;

    logic [31:0] tohost;
    host_cmd_e   cmd;
    logic        host_wr;

    assign host_wr = wr_en && (wr_addr == TOHOST_ADDR);
    assign cmd     = host_cmd_e'(tohost[31:16]);

    // Print command stays in the register for a single cycle
    assign char_we   = (cmd == CMD_PRINT_CHAR);
    assign char_data = tohost[7:0];

    always_ff @(posedge CLK) begin
        if (reset) begin
            tohost <= '0;
            finish <= 1'b0;
        end else begin
            if (host_wr) begin
                tohost <= wr_data;
            end else if (char_we) begin
                tohost <= '0;
            end
            // Sticky until reset
            if (host_wr && (wr_data[31:16] == CMD_POWER_OFF)) begin
                finish <= 1'b1;
            end
        end
    end

    // Holds because proc_busy blocks host writes during the pulse
    assert property (@(posedge CLK) disable iff (reset)
        char_we |=> !char_we);

endmodule

`default_nettype wire

// ==== list.f ====
mem_pkg.sv
mem_decode.sv
console_fifo.sv
host_cmd.sv
load_format.sv
mem_interconnect.sv
tb_checker.sv
tb_mem_interconnect.sv

// ==== load_format.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_format (
    input  wire mem_pkg::resp_sel_t resp_sel,
    input  wire [127:0]             dram_rdata,
    input  wire [31:0]              plic_rdata,
    input  wire [31:0]              clint_rdata,
    input  wire [7:0]               fifo_data,
    output logic [31:0]             data_rdata,
    output logic                    is_dram_data
);
    import mem_pkg::*;

    logic [LINE_W-1:0] line_shift;
    logic [DATA_W-1:0] word;
    logic [DATA_W-1:0] dram_data;

    // Byte offset within the 16-byte line
    assign line_shift = dram_rdata >> {resp_sel.offset, 3'b000};
    assign word       = line_shift[DATA_W-1:0];

    always_comb begin
        case (resp_sel.op)
            OP_LB:   dram_data = {{24{word[7]}}, word[7:0]};
            OP_LBU:  dram_data = {24'h0, word[7:0]};
            OP_LH:   dram_data = {{16{word[15]}}, word[15:0]};
            OP_LHU:  dram_data = {16'h0, word[15:0]};
            default: dram_data = word;
        endcase
    end

    // Unmapped regions and other VirtIO sub-devices read as zero
    always_comb begin
        case (resp_sel.dev)
            DEV_PLIC: begin
                data_rdata = plic_rdata;
            end
            DEV_CLINT: begin
                data_rdata = clint_rdata;
            end
            DEV_VIRTIO: begin
                data_rdata = (resp_sel.virt == VIRT_FIFO) ? {24'h0, fifo_data} : '0;
            end
            default: begin
                data_rdata = resp_sel.is_dram ? dram_data : '0;
            end
        endcase
    end

    assign is_dram_data = resp_sel.is_dram;

endmodule

`default_nettype wire

// ==== mem_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_decode (
    input  wire                     CLK,
    input  wire                     reset,
    input  wire mem_pkg::cpu_req_t  cpu_req,
    input  wire                     dram_busy,
    output mem_pkg::dram_req_t      dram_req,
    output logic                    plic_we,
    output logic                    plic_re,
    output logic                    clint_we,
    output logic                    fifo_pop,
    output mem_pkg::resp_sel_t      resp_sel
);
    import mem_pkg::*;

    dev_e       dev;
    logic [3:0] virt;
    logic       is_dram;
    logic       rd_req;
    logic       wr_req;

    assign dev     = dev_e'(cpu_req.addr[31:28]);
    assign virt    = cpu_req.addr[27:24];
    assign is_dram = (dev == DEV_DRAM) || (dev == DEV_DRAM0);

    // Requests are dropped while busy; a write wins over a read
    assign wr_req = cpu_req.we && !dram_busy;
    assign rd_req = cpu_req.re && !cpu_req.we && !dram_busy;

    always_comb begin
        dram_req.rd_en = rd_req && is_dram;
        dram_req.wr_en = wr_req && is_dram;
        dram_req.addr  = cpu_req.addr & DRAM_ADDR_MASK;
        dram_req.wdata = cpu_req.wdata;
        dram_req.op    = cpu_req.op;
    end

    assign plic_we  = wr_req && (dev == DEV_PLIC);
    assign plic_re  = rd_req && (dev == DEV_PLIC);
    assign clint_we = wr_req && (dev == DEV_CLINT);
    assign fifo_pop = rd_req && (dev == DEV_VIRTIO) && (virt == VIRT_FIFO);

    // Response attributes for the cycle after the read
    always_ff @(posedge CLK) begin
        if (reset) begin
            resp_sel <= '0;
        end else if (rd_req) begin
            resp_sel.dev     <= dev;
            resp_sel.virt    <= virt;
            resp_sel.offset  <= cpu_req.addr[3:0];
            resp_sel.op      <= cpu_req.op;
            resp_sel.is_dram <= is_dram;
        end
    end

    // DRAM never sees a read and a write in one cycle
    assert property (@(posedge CLK) disable iff (reset)
        !(dram_req.rd_en && dram_req.wr_en));

    // Back-pressure holds every strobe low
    assert property (@(posedge CLK) disable iff (reset)
        dram_busy |-> !(dram_req.rd_en || dram_req.wr_en || plic_we || plic_re
                        || clint_we || fifo_pop));

endmodule

`default_nettype wire

// ==== mem_interconnect.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_interconnect #(
    parameter int          FIFO_DEPTH  = 16,
    parameter logic [31:0] TOHOST_ADDR = 32'h4000_8000
) (
    input  wire                     CLK,
    input  wire                     reset,
    input  wire mem_pkg::cpu_req_t  cpu_req,
    input  wire                     dram_busy,
    input  wire [127:0]             dram_rdata,
    input  wire [31:0]              plic_rdata,
    input  wire [31:0]              clint_rdata,
    input  wire                     rx_valid,
    input  wire [7:0]               rx_data,
    output mem_pkg::dram_req_t      dram_req,
    output logic                    plic_we,
    output logic                    plic_re,
    output logic                    clint_we,
    output logic [31:0]             data_rdata,
    output logic                    is_dram_data,
    output logic                    proc_busy,
    output logic                    char_we,
    output logic [7:0]              char_data,
    output logic                    finish
);
    import mem_pkg::*;

    resp_sel_t  resp_sel;
    logic       fifo_pop;
    logic [7:0] fifo_head;
    logic       host_wr_en;

    // CPU holds its request while a character is pending or DRAM is busy
    assign proc_busy  = dram_busy || char_we;
    assign host_wr_en = cpu_req.we && !proc_busy;

    // Decoder is gated by the full stall, not only by DRAM
    mem_decode mem_decode_i (
        .CLK       (CLK),
        .reset     (reset),
        .cpu_req   (cpu_req),
        .dram_busy (proc_busy),
        .dram_req  (dram_req),
        .plic_we   (plic_we),
        .plic_re   (plic_re),
        .clint_we  (clint_we),
        .fifo_pop  (fifo_pop),
        .resp_sel  (resp_sel)
    );

    console_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) console_fifo_i (
        .CLK       (CLK),
        .reset     (reset),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .pop       (fifo_pop),
        .head_data (fifo_head)
    );

    host_cmd #(
        .TOHOST_ADDR (TOHOST_ADDR)
    ) host_cmd_i (
        .CLK       (CLK),
        .reset     (reset),
        .wr_addr   (cpu_req.addr),
        .wr_data   (cpu_req.wdata),
        .wr_en     (host_wr_en),
        .char_we   (char_we),
        .char_data (char_data),
        .finish    (finish)
    );

    load_format load_format_i (
        .resp_sel     (resp_sel),
        .dram_rdata   (dram_rdata),
        .plic_rdata   (plic_rdata),
        .clint_rdata  (clint_rdata),
        .fifo_data    (fifo_head),
        .data_rdata   (data_rdata),
        .is_dram_data (is_dram_data)
    );

endmodule

`default_nettype wire

// ==== mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    parameter int DATA_W = 32;
    parameter int LINE_W = 128;

    // Console receive FIFO sits at this VirtIO sub-device
    parameter logic [3:0] VIRT_FIFO = 4'd6;

    // DRAM window seen by the memory controller
    parameter logic [31:0] DRAM_ADDR_MASK = 32'h07ff_ffff;

    // Access width in funct3 encoding; stores reuse LB/LH/LW with we set
    typedef enum logic [2:0] {
        OP_LB  = 3'd0,
        OP_LH  = 3'd1,
        OP_LW  = 3'd2,
        OP_LBU = 3'd4,
        OP_LHU = 3'd5
    } mem_op_e;

    // Top address nibble
    typedef enum logic [3:0] {
        DEV_DRAM0  = 4'h0,
        DEV_VIRTIO = 4'h4,
        DEV_PLIC   = 4'h5,
        DEV_CLINT  = 4'h6,
        DEV_DRAM   = 4'h8
    } dev_e;

    // Upper half of the host register
    typedef enum logic [15:0] {
        CMD_PRINT_CHAR = 16'h0001,
        CMD_POWER_OFF  = 16'h0002
    } host_cmd_e;

    typedef struct packed {
        logic [31:0]       addr;
        logic [DATA_W-1:0] wdata;
        logic              we;
        logic              re;
        mem_op_e           op;
    } cpu_req_t;

    typedef struct packed {
        logic              rd_en;
        logic              wr_en;
        logic [31:0]       addr;
        logic [DATA_W-1:0] wdata;
        mem_op_e           op;
    } dram_req_t;

    // Attributes of the last accepted read, used in the response cycle
    typedef struct packed {
        dev_e       dev;
        logic [3:0] virt;
        logic [3:0] offset;
        mem_op_e    op;
        logic       is_dram;
    } resp_sel_t;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the interconnect testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_mem_interconnect \
    -f list.f -o sim_tb > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0

// ==== tb_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_checker #(
    parameter int          FIFO_DEPTH  = 16,
    parameter logic [31:0] TOHOST_ADDR = 32'h4000_8000
) (
    input  wire                     CLK,
    input  wire                     reset,
    input  wire mem_pkg::cpu_req_t  cpu_req,
    input  wire                     dram_busy,
    input  wire [127:0]             dram_rdata,
    input  wire [31:0]              plic_rdata,
    input  wire [31:0]              clint_rdata,
    input  wire                     rx_valid,
    input  wire [7:0]               rx_data,
    input  wire mem_pkg::dram_req_t dram_req,
    input  wire                     plic_we,
    input  wire                     plic_re,
    input  wire                     clint_we,
    input  wire [31:0]              data_rdata,
    input  wire                     is_dram_data,
    input  wire                     proc_busy,
    input  wire                     char_we,
    input  wire [7:0]               char_data,
    input  wire                     finish,
    input  wire                     done,
    output logic [31:0]             error_count,
    output logic                    report_done
);
    import mem_pkg::*;

    // Where the response word of the last accepted read comes from
    typedef enum logic [2:0] {
        SRC_ZERO,
        SRC_FIFO,
        SRC_PLIC,
        SRC_CLINT,
        SRC_DRAM
    } resp_src_e;

    logic [7:0] fifo_q [$];
    resp_src_e  resp_src;
    logic       resp_pending = 1'b0;
    logic [7:0] resp_byte;
    logic [3:0] resp_offset;
    logic [2:0] resp_op;
    logic       exp_char_we = 1'b0;
    logic [7:0] exp_char_data;
    logic       exp_finish = 1'b0;
    int         checks = 0;
    int         errors = 0;
    logic       reported = 1'b0;

    assign error_count = errors;
    assign report_done = reported;

    // Bytes past the end of the line read as zero
    function automatic logic [31:0] expected_load(input logic [127:0] line,
                                                  input logic [3:0]   offset,
                                                  input logic [2:0]   op);
        logic [31:0] word;
        int          pos;
        word = '0;
        for (int i = 0; i < 4; i++) begin
            pos = int'(offset) + i;
            if (pos < 16) begin
                word[i*8 +: 8] = line[pos*8 +: 8];
            end
        end
        case (op)
            OP_LB:   return {{24{word[7]}}, word[7:0]};
            OP_LBU:  return {24'h0, word[7:0]};
            OP_LH:   return {{16{word[15]}}, word[15:0]};
            OP_LHU:  return {16'h0, word[15:0]};
            default: return word;
        endcase
    endfunction

    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    always @(posedge CLK) begin : watch
        logic        busy_exp;
        logic        acc_wr;
        logic        acc_rd;
        logic        is_dram;
        logic        pop;
        logic        was_full;
        logic        host_wr;
        logic [3:0]  dev;
        logic [7:0]  popped;
        logic [31:0] exp_word;

        if (reset) begin
            fifo_q.delete();
            resp_pending = 1'b0;
            exp_char_we  = 1'b0;
            exp_finish   = 1'b0;
        end else begin
            busy_exp = dram_busy || exp_char_we;
            acc_wr   = cpu_req.we && !busy_exp;
            acc_rd   = cpu_req.re && !cpu_req.we && !busy_exp;
            dev      = cpu_req.addr[31:28];
            is_dram  = (dev == 4'h0) || (dev == 4'h8);

            // Response to the read of the previous cycle
            if (resp_pending) begin
                case (resp_src)
                    SRC_DRAM:  exp_word = expected_load(dram_rdata, resp_offset, resp_op);
                    SRC_PLIC:  exp_word = plic_rdata;
                    SRC_CLINT: exp_word = clint_rdata;
                    SRC_FIFO:  exp_word = {24'h0, resp_byte};
                    default:   exp_word = '0;
                endcase
                check_word("data_rdata", data_rdata, exp_word);
                check_bit("is_dram_data", is_dram_data, resp_src == SRC_DRAM);
            end

            check_bit("proc_busy", proc_busy, busy_exp);
            check_bit("dram rd_en", dram_req.rd_en, acc_rd && is_dram);
            check_bit("dram wr_en", dram_req.wr_en, acc_wr && is_dram);
            check_bit("plic_we", plic_we, acc_wr && (dev == 4'h5));
            check_bit("plic_re", plic_re, acc_rd && (dev == 4'h5));
            check_bit("clint_we", clint_we, acc_wr && (dev == 4'h6));
            if ((acc_rd || acc_wr) && is_dram) begin
                check_word("dram addr", dram_req.addr, cpu_req.addr & 32'h07ff_ffff);
                check_word("dram op", {29'h0, dram_req.op}, {29'h0, cpu_req.op});
            end
            if (acc_wr && is_dram) begin
                check_word("dram wdata", dram_req.wdata, cpu_req.wdata);
            end
            check_bit("char_we", char_we, exp_char_we);
            if (exp_char_we) begin
                check_word("char_data", {24'h0, char_data}, {24'h0, exp_char_data});
            end
            check_bit("finish", finish, exp_finish);

            // Queue model of the console FIFO
            pop      = acc_rd && (dev == 4'h4) && (cpu_req.addr[27:24] == 4'h6);
            was_full = fifo_q.size() >= FIFO_DEPTH;
            popped   = 8'h00;
            if (pop && fifo_q.size() > 0) begin
                popped = fifo_q.pop_front();
            end
            if (rx_valid && !was_full) begin
                fifo_q.push_back(rx_data);
            end

            resp_pending = acc_rd;
            resp_byte    = popped;
            resp_offset  = cpu_req.addr[3:0];
            resp_op      = cpu_req.op;
            if (is_dram) begin
                resp_src = SRC_DRAM;
            end else if (dev == 4'h5) begin
                resp_src = SRC_PLIC;
            end else if (dev == 4'h6) begin
                resp_src = SRC_CLINT;
            end else if (pop) begin
                resp_src = SRC_FIFO;
            end else begin
                resp_src = SRC_ZERO;
            end

            host_wr       = acc_wr && (cpu_req.addr == TOHOST_ADDR);
            exp_char_we   = host_wr && (cpu_req.wdata[31:16] == 16'h0001);
            exp_char_data = cpu_req.wdata[7:0];
            if (host_wr && (cpu_req.wdata[31:16] == 16'h0002)) begin
                exp_finish = 1'b1;
            end
        end

        if (done && !reported) begin
            $display("Checks run: %0d, errors: %0d", checks, errors);
            reported = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== tb_mem_interconnect.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_interconnect;
    import mem_pkg::*;

    localparam int          CLK_PERIOD  = 20;
    localparam int          NUM_REQ     = 2000;
    localparam int          FIFO_DEPTH  = 16;
    localparam logic [31:0] TOHOST_ADDR = 32'h4000_8000;

    logic         CLK = 1'b0;
    logic         reset;
    cpu_req_t     cpu_req;
    logic         dram_busy;
    logic [127:0] dram_rdata;
    logic [31:0]  plic_rdata;
    logic [31:0]  clint_rdata;
    logic         rx_valid;
    logic [7:0]   rx_data;
    dram_req_t    dram_req;
    logic         plic_we;
    logic         plic_re;
    logic         clint_we;
    logic [31:0]  data_rdata;
    logic         is_dram_data;
    logic         proc_busy;
    logic         char_we;
    logic [7:0]   char_data;
    logic         finish;
    logic         done;
    logic [31:0]  error_count;
    logic         report_done;

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    mem_interconnect #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .TOHOST_ADDR (TOHOST_ADDR)
    ) mem_interconnect_i (.*);

    tb_checker #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .TOHOST_ADDR (TOHOST_ADDR)
    ) checker_i (.*);

    // Line contents depend on every address bit
    function automatic logic [127:0] line_of(input logic [31:0] addr);
        logic [127:0] line;
        logic [31:0]  k;
        for (int i = 0; i < 4; i++) begin
            k = 32'(i);
            line[i*32 +: 32] = (addr * (2 * k + 32'd3)) ^ {addr[15:0], addr[31:16]}
                               ^ (k * 32'h9e37_79b9);
        end
        return line;
    endfunction

    // DRAM, PLIC and CLINT answer one cycle after the request
    always @(posedge CLK) begin
        dram_rdata  <= line_of(cpu_req.addr);
        plic_rdata  <= cpu_req.addr ^ 32'h5a5a_0000;
        clint_rdata <= ~cpu_req.addr + 32'd7;
    end

    task automatic drive_random(input int idx);
        cpu_req_t    req;
        int unsigned pick;
        int unsigned kind;
        int unsigned rx_span;
        logic [3:0]  dev;
        logic [3:0]  virt;

        pick = $urandom_range(0, 15);
        virt = 4'($urandom_range(0, 15));
        case (pick)
            0, 1, 2, 3, 4: dev = 4'h8;
            5, 6:          dev = 4'h0;
            7, 8: begin
                dev  = 4'h4;
                virt = 4'h6;
            end
            9:             dev = 4'h4;
            10, 11:        dev = 4'h5;
            12, 13:        dev = 4'h6;
            default:       dev = 4'h3;
        endcase
        req.addr = $urandom;
        req.addr[31:28] = dev;
        if (dev == 4'h4) begin
            req.addr[27:24] = virt;
        end
        req.wdata = $urandom;
        case ($urandom_range(0, 4))
            0:       req.op = OP_LB;
            1:       req.op = OP_LH;
            2:       req.op = OP_LW;
            3:       req.op = OP_LBU;
            default: req.op = OP_LHU;
        endcase
        kind   = $urandom_range(0, 9);
        req.re = (kind < 6);
        req.we = (kind >= 6) && (kind < 9);

        // Occasional print-char command
        if ($urandom_range(0, 63) == 0) begin
            req.addr  = TOHOST_ADDR;
            req.we    = 1'b1;
            req.re    = 1'b0;
            req.wdata = {16'h0001, 8'h00, 8'($urandom)};
        end

        // Heavy receive traffic first so the FIFO overflows, then it drains
        rx_span = (idx < NUM_REQ / 2) ? 1 : 31;

        @(posedge CLK);
        cpu_req   <= req;
        dram_busy <= ($urandom_range(0, 7) == 0);
        rx_valid  <= ($urandom_range(0, rx_span) == 0);
        rx_data   <= 8'($urandom);
    endtask

    initial begin
        void'($urandom(70));
        reset       = 1'b1;
        cpu_req     = '0;
        dram_busy   = 1'b0;
        dram_rdata  = '0;
        plic_rdata  = '0;
        clint_rdata = '0;
        rx_valid    = 1'b0;
        rx_data     = '0;
        done        = 1'b0;
        repeat (4) @(posedge CLK);
        reset <= 1'b0;

        for (int i = 0; i < NUM_REQ; i++) begin
            drive_random(i);
        end

        // Idle bus lets a pending character pulse end
        @(posedge CLK);
        cpu_req   <= '0;
        dram_busy <= 1'b0;
        rx_valid  <= 1'b0;
        repeat (3) @(posedge CLK);
        cpu_req <= '{addr: TOHOST_ADDR, wdata: {CMD_POWER_OFF, 16'h0000},
                     we: 1'b1, re: 1'b0, op: OP_LW};
        @(posedge CLK);
        cpu_req <= '0;
        while (!finish) begin
            @(posedge CLK);
        end
        repeat (4) @(posedge CLK);
        done <= 1'b1;
        wait (report_done);
        @(negedge CLK);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Four clock periods per request bounds the run
    initial begin
        #(CLK_PERIOD * NUM_REQ * 4);
        $display("Timeout: the run did not reach power-off within %0d ns",
                 CLK_PERIOD * NUM_REQ * 4);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
